// ==== list.f ====
src/snakePkg.sv
src/snakeIf.sv
src/fieldConfigRegs.sv
src/bodyTracker.sv
src/collisionDetector.sv
src/gameController.sv
src/snakeTop.sv
verif/snakeChecker.sv
verif/snakeTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module snakeTb -f list.f -o simv

# a failing assertion stops the model, so keep going and judge the log
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
exit 0

// ==== src/bodyTracker.sv ====
module bodyTracker #(
    parameter int MAX_LENGTH = 16
) (
    input  logic            clk,
    input  logic            nrst,
    fieldConfigIf.consumer  cfg,
    input  logic            load,
    input  logic            move,
    input  logic            grow,
    input  snakePkg::coordT newX,
    input  snakePkg::coordT newY,
    snakeBodyIf.owner       body
);
    import snakePkg::*;

    localparam int LEN_W = $clog2(MAX_LENGTH + 1);

    coordT [MAX_LENGTH-1:0] segX;
    coordT [MAX_LENGTH-1:0] segY;
    logic  [LEN_W-1:0]      length;

    // slot 0 is the head, higher slots trail behind it
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            segX   <= '0;
            segY   <= '0;
            length <= LEN_W'(1);
        end else if (load) begin
            // fresh one-cell snake on the start square
            segX[0] <= cfg.startX;
            segY[0] <= cfg.startY;
            length  <= LEN_W'(1);
        end else if (move || grow) begin
            // everything slides one slot towards the tail
            for (int i = MAX_LENGTH - 1; i > 0; i--) begin
                segX[i] <= segX[i-1];
                segY[i] <= segY[i-1];
            end
            segX[0] <= newX;
            segY[0] <= newY;
            // old tail survives in slot length on a grow
            if (grow && (length < LEN_W'(MAX_LENGTH))) begin
                length <= length + LEN_W'(1);
            end
        end
    end

    // slots at or past length are stale and ignored downstream
    assign body.segX   = segX;
    assign body.segY   = segY;
    assign body.headX  = segX[0];
    assign body.headY  = segY[0];
    assign body.length = length;

endmodule

// ==== src/collisionDetector.sv ====
module collisionDetector #(
    parameter int MAX_LENGTH = 16,
    parameter int NUM_WALLS  = 4
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            checkEnable,
    input  snakePkg::coordT nextX,
    input  snakePkg::coordT nextY,
    fieldConfigIf.consumer  cfg,
    snakeBodyIf.viewer      body,
    output logic            badCollision,
    output logic            goodCollision1,
    output logic            goodCollision2
);
    import snakePkg::*;

    logic borderHit;
    logic wallHit;
    logic bodyHit;
    logic apple1Hit;
    logic apple2Hit;

    // border cells themselves count as a hit
    assign borderHit = (nextX <= cfg.xMin) || (nextX >= cfg.xMax) ||
                       (nextY <= cfg.yMin) || (nextY >= cfg.yMax);

    // only enabled walls block
    always_comb begin
        wallHit = 1'b0;
        for (int i = 0; i < NUM_WALLS; i++) begin
            if (cfg.wallEn[i] && (cfg.wallX[i] == nextX) && (cfg.wallY[i] == nextY)) begin
                wallHit = 1'b1;
            end
        end
    end

    // live segments only, tail included
    always_comb begin
        bodyHit = 1'b0;
        for (int i = 0; i < MAX_LENGTH; i++) begin
            if ((i < int'(body.length)) &&
                (body.segX[i] == nextX) && (body.segY[i] == nextY)) begin
                bodyHit = 1'b1;
            end
        end
    end

    assign apple1Hit = (nextX == cfg.apple1X) && (nextY == cfg.apple1Y);
    assign apple2Hit = (nextX == cfg.apple2X) && (nextY == cfg.apple2Y);

    // verdict captured at the end of the tick cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            badCollision   <= 1'b0;
            goodCollision1 <= 1'b0;
            goodCollision2 <= 1'b0;
        end else if (checkEnable) begin
            badCollision   <= borderHit || wallHit || bodyHit;
            goodCollision1 <= apple1Hit;
            goodCollision2 <= apple2Hit;
        end
    end

endmodule

// ==== src/fieldConfigRegs.sv ====
module fieldConfigRegs #(
    parameter int NUM_WALLS = 4
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       wbCyc,
    input  logic                       wbStb,
    input  logic                       wbWe,
    input  logic [3:0]                 wbAdr,
    input  logic [snakePkg::DATA_W-1:0] wbDatW,
    output logic [snakePkg::DATA_W-1:0] wbDatR,
    output logic                       wbAck,
    fieldConfigIf.provider             cfg
);
    import snakePkg::*;

    // wall word: x in 3:0, y in 7:4, enable in 8
    localparam int WALL_W = 2 * COORD_W + 1;

    regAddrT addr;
    logic    access;
    logic    run;
    logic    restart;
    logic [DATA_W-1:0] borderReg;
    logic [DATA_W-1:0] appleReg;
    logic [2*COORD_W-1:0] startReg;
    logic [NUM_WALLS-1:0][WALL_W-1:0] wallReg;
    logic [NUM_WALLS-1:0] wallSel;
    logic [DATA_W-1:0] readData;

    assign addr = regAddrT'(wbAdr);

    // new cycle seen and no ack outstanding
    assign access = wbCyc && wbStb && !wbAck;

    // one select per wall word
    always_comb begin
        for (int i = 0; i < NUM_WALLS; i++) begin
            wallSel[i] = (wbAdr == 4'(int'(WALL0) + i));
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wbAck     <= 1'b0;
            run       <= 1'b0;
            restart   <= 1'b0;
            borderReg <= '0;
            appleReg  <= '0;
            startReg  <= '0;
            wallReg   <= '0;
        end else begin
            // ack is always one cycle long
            wbAck   <= access;
            // restart drops again after one cycle
            restart <= 1'b0;
            if (access && wbWe) begin
                case (addr)
                    CTRL: begin
                        run     <= wbDatW[0];
                        restart <= wbDatW[1];
                    end
                    BORDER: borderReg <= wbDatW;
                    APPLE:  appleReg  <= wbDatW;
                    START:  startReg  <= wbDatW[2*COORD_W-1:0];
                    default: begin
                        // unmapped words fall through untouched
                        for (int i = 0; i < NUM_WALLS; i++) begin
                            if (wallSel[i]) begin
                                wallReg[i] <= wbDatW[WALL_W-1:0];
                            end
                        end
                    end
                endcase
            end
        end
    end

    // read mux, held stable by the master through the ack
    always_comb begin
        readData = '0;
        case (addr)
            CTRL:   readData[0] = run;
            BORDER: readData = borderReg;
            APPLE:  readData = appleReg;
            START:  readData[2*COORD_W-1:0] = startReg;
            default: begin
                for (int i = 0; i < NUM_WALLS; i++) begin
                    if (wallSel[i]) begin
                        readData[WALL_W-1:0] = wallReg[i];
                    end
                end
            end
        endcase
    end

    assign wbDatR = readData;

    // nibble unpacking onto the config bus
    assign cfg.xMin    = borderReg[3:0];
    assign cfg.xMax    = borderReg[7:4];
    assign cfg.yMin    = borderReg[11:8];
    assign cfg.yMax    = borderReg[15:12];
    assign cfg.apple1X = appleReg[3:0];
    assign cfg.apple1Y = appleReg[7:4];
    assign cfg.apple2X = appleReg[11:8];
    assign cfg.apple2Y = appleReg[15:12];
    assign cfg.startX  = startReg[3:0];
    assign cfg.startY  = startReg[7:4];
    assign cfg.run     = run;
    assign cfg.restart = restart;

    always_comb begin
        for (int i = 0; i < NUM_WALLS; i++) begin
            cfg.wallX[i]  = wallReg[i][3:0];
            cfg.wallY[i]  = wallReg[i][7:4];
            cfg.wallEn[i] = wallReg[i][8];
        end
    end

endmodule

// ==== src/gameController.sv ====
module gameController (
    input  logic            clk,
    input  logic            nrst,
    input  logic            tick,
    input  snakePkg::dirT   dirIn,
    fieldConfigIf.consumer  cfg,
    snakeBodyIf.viewer      body,
    input  logic            badCollision,
    input  logic            goodCollision1,
    input  logic            goodCollision2,
    output logic            checkEnable,
    output snakePkg::coordT nextX,
    output snakePkg::coordT nextY,
    output logic            load,
    output logic            move,
    output logic            grow,
    output logic [7:0]      score,
    output logic            gameOver,
    output logic            appleEaten
);
    import snakePkg::*;

    gameStateT state, stateNext;
    dirT       dir;
    dirT       stepDir;
    logic      accept;
    logic      ateApple;

    function automatic dirT opposite(input dirT d);
        case (d)
            UP:      return DOWN;
            DOWN:    return UP;
            LEFT:    return RIGHT;
            default: return LEFT;
        endcase
    endfunction

    // ticks only count while running, anything else is dropped
    assign accept = (state == RUN) && cfg.run && tick;

    // a reversal request keeps the old heading
    assign stepDir = (accept && (dirIn != opposite(dir))) ? dirIn : dir;

    // one cell ahead, 4-bit wrap
    always_comb begin
        nextX = body.headX;
        nextY = body.headY;
        case (stepDir)
            UP:      nextY = body.headY - coordT'(1);
            DOWN:    nextY = body.headY + coordT'(1);
            LEFT:    nextX = body.headX - coordT'(1);
            default: nextX = body.headX + coordT'(1);
        endcase
    end

    assign ateApple    = goodCollision1 || goodCollision2;
    assign checkEnable = accept;
    assign load        = (state == IDLE);
    // body untouched on a bad verdict or restart
    assign grow = (state == CHECK) && !cfg.restart && !badCollision && ateApple;
    assign move = (state == CHECK) && !cfg.restart && !badCollision && !ateApple;

    always_comb begin
        stateNext = state;
        case (state)
            IDLE:    if (cfg.run) stateNext = RUN;
            RUN:     if (accept) stateNext = CHECK;
            CHECK:   stateNext = badCollision ? OVER : RUN;
            default: stateNext = OVER;
        endcase
        // restart wins from anywhere
        if (cfg.restart) begin
            stateNext = IDLE;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= IDLE;
            dir        <= RIGHT;
            score      <= '0;
            gameOver   <= 1'b0;
            appleEaten <= 1'b0;
        end else begin
            state      <= stateNext;
            appleEaten <= grow;
            if (accept) begin
                dir <= stepDir;
            end
            if (grow) begin
                score <= score + 8'd1;
            end
            if ((state == CHECK) && badCollision && !cfg.restart) begin
                gameOver <= 1'b1;
            end
            // fresh game set-up while idle
            if (state == IDLE) begin
                dir      <= RIGHT;
                score    <= '0;
                gameOver <= 1'b0;
            end
            if (cfg.restart) begin
                gameOver <= 1'b0;
            end
        end
    end

endmodule

// ==== src/snakeIf.sv ====
// field set-up as seen by the game blocks
interface fieldConfigIf #(
    parameter int NUM_WALLS = 4
);
    import snakePkg::*;

    // playfield limits, cells on or past them are fatal
    coordT xMin, xMax, yMin, yMax;
    coordT apple1X, apple1Y, apple2X, apple2Y;
    coordT [NUM_WALLS-1:0] wallX;
    coordT [NUM_WALLS-1:0] wallY;
    logic  [NUM_WALLS-1:0] wallEn;
    coordT startX, startY;
    logic  run;
    // single-cycle pulse
    logic  restart;

    modport provider (
        output xMin, xMax, yMin, yMax, apple1X, apple1Y, apple2X, apple2Y,
               wallX, wallY, wallEn, startX, startY, run, restart
    );
    modport consumer (
        input  xMin, xMax, yMin, yMax, apple1X, apple1Y, apple2X, apple2Y,
               wallX, wallY, wallEn, startX, startY, run, restart
    );
endinterface

// snake segment view, slot 0 is the head
interface snakeBodyIf #(
    parameter int MAX_LENGTH = 16,
    parameter int LEN_W = $clog2(MAX_LENGTH + 1)
);
    import snakePkg::*;

    coordT headX, headY;
    coordT [MAX_LENGTH-1:0] segX;
    coordT [MAX_LENGTH-1:0] segY;
    logic  [LEN_W-1:0] length;

    modport owner  (output headX, headY, segX, segY, length);
    modport viewer (input  headX, headY, segX, segY, length);
endinterface

// ==== src/snakePkg.sv ====
package snakePkg;

    // grid is 16 x 16, one nibble per axis
    localparam int COORD_W = 4;

    // wishbone data bus
    localparam int DATA_W = 16;

    typedef logic [COORD_W-1:0] coordT;

    // UP lowers y, LEFT lowers x
    typedef enum logic [1:0] {
        UP    = 2'd0,
        DOWN  = 2'd1,
        LEFT  = 2'd2,
        RIGHT = 2'd3
    } dirT;

    // controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        CHECK = 2'd2,
        OVER  = 2'd3
    } gameStateT;

    // register word addresses
    // wall i sits at WALL0 + i
    typedef enum logic [3:0] {
        CTRL   = 4'd0,
        BORDER = 4'd1,
        APPLE  = 4'd2,
        START  = 4'd3,
        WALL0  = 4'd4
    } regAddrT;

endpackage

// ==== src/snakeTop.sv ====
module snakeTop #(
    parameter int MAX_LENGTH = 16,
    parameter int NUM_WALLS  = 4
) (
    input  logic                                 clk,
    input  logic                                 nrst,
    input  logic                                 wbCyc,
    input  logic                                 wbStb,
    input  logic                                 wbWe,
    input  logic [3:0]                           wbAdr,
    input  logic [snakePkg::DATA_W-1:0]          wbDatW,
    input  logic                                 tick,
    input  snakePkg::dirT                        dirIn,
    output logic [snakePkg::DATA_W-1:0]          wbDatR,
    output logic                                 wbAck,
    output snakePkg::coordT                      headX,
    output snakePkg::coordT                      headY,
    output logic [$clog2(MAX_LENGTH + 1)-1:0]    length,
    output logic [7:0]                           score,
    output logic                                 gameOver,
    output logic                                 appleEaten
);
    import snakePkg::*;

    logic  checkEnable;
    logic  load;
    logic  move;
    logic  grow;
    logic  badCollision;
    logic  goodCollision1;
    logic  goodCollision2;
    coordT nextX;
    coordT nextY;

    fieldConfigIf #(.NUM_WALLS(NUM_WALLS)) cfgBus ();
    snakeBodyIf #(.MAX_LENGTH(MAX_LENGTH)) bodyBus ();

    // software-visible set-up
    fieldConfigRegs #(.NUM_WALLS(NUM_WALLS)) regs (
        .clk(clk), .nrst(nrst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .cfg(cfgBus.provider)
    );

    bodyTracker #(.MAX_LENGTH(MAX_LENGTH)) tracker (
        .clk(clk), .nrst(nrst), .cfg(cfgBus.consumer), .load(load),
        .move(move), .grow(grow), .newX(nextX), .newY(nextY),
        .body(bodyBus.owner)
    );

    collisionDetector #(.MAX_LENGTH(MAX_LENGTH), .NUM_WALLS(NUM_WALLS)) detector (
        .clk(clk), .nrst(nrst), .checkEnable(checkEnable), .nextX(nextX),
        .nextY(nextY), .cfg(cfgBus.consumer), .body(bodyBus.viewer),
        .badCollision(badCollision), .goodCollision1(goodCollision1),
        .goodCollision2(goodCollision2)
    );

    // step sequencing and scoring
    gameController ctrl (
        .clk(clk), .nrst(nrst), .tick(tick), .dirIn(dirIn),
        .cfg(cfgBus.consumer), .body(bodyBus.viewer),
        .badCollision(badCollision), .goodCollision1(goodCollision1),
        .goodCollision2(goodCollision2), .checkEnable(checkEnable),
        .nextX(nextX), .nextY(nextY), .load(load), .move(move), .grow(grow),
        .score(score), .gameOver(gameOver), .appleEaten(appleEaten)
    );

    assign headX  = bodyBus.headX;
    assign headY  = bodyBus.headY;
    assign length = bodyBus.length;

endmodule

// ==== verif/snakeChecker.sv ====
module snakeChecker #(
    parameter int MAX_LENGTH = 16
) (
    input logic                                clk,
    input logic                                nrst,
    input logic                                wbCyc,
    input logic                                wbStb,
    input logic                                wbAck,
    input snakePkg::coordT                     headX,
    input snakePkg::coordT                     headY,
    input logic [$clog2(MAX_LENGTH + 1)-1:0]   length,
    input logic [7:0]                          score,
    input logic                                gameOver,
    input logic                                appleEaten
);
    import snakePkg::*;

    localparam int LEN_W = $clog2(MAX_LENGTH + 1);

    // ack lasts exactly one cycle
    ackOnePulse: assert property (@(posedge clk) disable iff (!nrst)
        wbAck |=> !wbAck)
        else $error("wbAck held for more than one cycle");

    // new request answered on the very next cycle
    ackAfterRequest: assert property (@(posedge clk) disable iff (!nrst)
        (wbCyc && wbStb && !wbAck) |=> wbAck)
        else $error("wbAck missing one cycle after a new request");

    // a meal grows the snake and bumps the score by one
    appleGrows: assert property (@(posedge clk) disable iff (!nrst)
        (appleEaten && ($past(length) < LEN_W'(MAX_LENGTH))) |->
            (score == $past(score) + 8'd1) && (length == $past(length) + LEN_W'(1)))
        else $error("apple eaten without score and length growth");

    // game over freezes the snake and the score
    overFreezes: assert property (@(posedge clk) disable iff (!nrst)
        gameOver |-> $stable(headX) && $stable(headY) && $stable(length) && $stable(score))
        else $error("snake changed while the game was over");

endmodule

bind snakeTop snakeChecker #(.MAX_LENGTH(MAX_LENGTH)) chk (.*);

// ==== verif/snakeTb.sv ====
module snakeTb;
    import snakePkg::*;

    logic clk, nrst, wbCyc, wbStb, wbWe, tick;
    logic [3:0] wbAdr;
    logic [15:0] wbDatW, wbDatR, rd;
    logic wbAck, gameOver, appleEaten;
    dirT dirIn;
    coordT headX, headY;
    logic [4:0] length;
    logic [7:0] score;

    snakeTop DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic expectEq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abortRun("value check failed");
        end
    endtask

    // one Wishbone classic cycle with the ack expected after a single edge
    task automatic wbAccess(input logic we, input logic [3:0] adr, input logic [15:0] wdat,
                            output logic [15:0] rdat);
        int n;
        @(posedge clk);
        #1;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = wdat;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wbAck && n < 16);
        if (!wbAck) abortRun("Wishbone ack never arrived");
        expectEq("ack latency", n, 1);
        rdat = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbWrite(input logic [3:0] adr, input logic [15:0] dat);
        logic [15:0] unused;
        wbAccess(1'b1, adr, dat, unused);
    endtask

    task automatic wbRead(input logic [3:0] adr, output logic [15:0] dat);
        wbAccess(1'b0, adr, 16'h0, dat);
    endtask

    task automatic checkReg(input logic [3:0] adr, input int exp, input string name);
        wbRead(adr, rd);
        expectEq(name, int'(rd), exp);
    endtask

    // tick on cycle T and results settle by T+2
    task automatic waitTicks(input dirT d, input int x, input int y, input int len,
                             input int sc, input int over, input int eaten);
        @(posedge clk);
        #1;
        tick = 1'b1;
        dirIn = d;
        @(posedge clk);
        #1;
        tick = 1'b0;
        @(posedge clk);
        #1;
        expectEq("headX", int'(headX), x);
        expectEq("headY", int'(headY), y);
        expectEq("length", int'(length), len);
        expectEq("score", int'(score), sc);
        expectEq("gameOver", int'(gameOver), over);
        expectEq("appleEaten", int'(appleEaten), eaten);
    endtask

    // restart with run kept on and wait for the one-cell snake at (5,5)
    task automatic restartGame();
        int n;
        wbWrite(CTRL, 16'h0003);
        n = 0;
        while (!(!gameOver && length == 5'd1 && headX == 4'd5 && headY == 4'd5
                 && score == 8'd0) && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= 20) abortRun("restart did not bring the snake back to the start cell");
    endtask

    initial begin
        nrst = 1'b0;
        tick = 1'b0;
        dirIn = RIGHT;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = 4'h0;
        wbDatW = 16'h0;
        repeat (10) @(posedge clk);
        #1;
        nrst = 1'b1;
        expectEq("gameOver", int'(gameOver), 0);
        expectEq("appleEaten", int'(appleEaten), 0);
        expectEq("wbAck", int'(wbAck), 0);
        expectEq("length", int'(length), 1);

        // borders 0/15, start (5,5), apples (7,5) and (7,7), wall0 at (10,7)
        wbWrite(BORDER, 16'hF0F0);
        wbWrite(START, 16'h0055);
        wbWrite(APPLE, 16'h7757);
        wbWrite(4'd4, 16'h017A);
        wbWrite(4'd5, 16'h00C3);
        wbWrite(4'd6, 16'h00D4);
        wbWrite(4'd7, 16'h00E5);
        wbWrite(CTRL, 16'h0002);
        // unmapped word must not land in any register
        wbWrite(4'd9, 16'hFFFF);
        checkReg(BORDER, 16'hF0F0, "BORDER");
        checkReg(START, 16'h0055, "START");
        checkReg(APPLE, 16'h7757, "APPLE");
        checkReg(4'd4, 16'h017A, "WALL0");
        checkReg(4'd5, 16'h00C3, "WALL1");
        checkReg(4'd6, 16'h00D4, "WALL2");
        checkReg(4'd7, 16'h00E5, "WALL3");
        checkReg(CTRL, 0, "CTRL");
        checkReg(4'd9, 0, "unused word");

        wbWrite(CTRL, 16'h0001);
        checkReg(CTRL, 1, "CTRL");
        waitTicks(RIGHT, 6, 5, 1, 0, 0, 0);
        // reverse request ignored so the head lands on apple1
        waitTicks(LEFT, 7, 5, 2, 1, 0, 1);
        waitTicks(DOWN, 7, 6, 2, 1, 0, 0);
        waitTicks(DOWN, 7, 7, 3, 2, 0, 1);
        waitTicks(RIGHT, 8, 7, 3, 2, 0, 0);
        waitTicks(RIGHT, 9, 7, 3, 2, 0, 0);
        // wall at (10,7)
        waitTicks(RIGHT, 9, 7, 3, 2, 1, 0);
        waitTicks(RIGHT, 9, 7, 3, 2, 1, 0);

        restartGame();
        for (int y = 4; y >= 1; y--) begin
            waitTicks(UP, 5, y, 1, 0, 0, 0);
        end
        // y = 0 is the border
        waitTicks(UP, 5, 1, 1, 0, 1, 0);

        restartGame();
        wbWrite(APPLE, 16'h5756);
        waitTicks(RIGHT, 6, 5, 2, 1, 0, 1);
        waitTicks(RIGHT, 7, 5, 3, 2, 0, 1);
        wbWrite(APPLE, 16'h5958);
        waitTicks(RIGHT, 8, 5, 4, 3, 0, 1);
        waitTicks(RIGHT, 9, 5, 5, 4, 0, 1);
        waitTicks(DOWN, 9, 6, 5, 4, 0, 0);
        waitTicks(LEFT, 8, 6, 5, 4, 0, 0);
        // (8,5) is still body
        waitTicks(UP, 8, 6, 5, 4, 1, 0);

        restartGame();
        waitTicks(RIGHT, 6, 5, 1, 0, 0, 0);

        $display("TEST PASSED");
        $finish;
    end

endmodule
